//--- logic/sd_demod_cfg.svh
`ifndef SD_DEMOD_CFG_SVH
`define SD_DEMOD_CFG_SVH

// Number of modulator channels sampled on data_in
`define SD_CHANNELS 2

// Width of an output sample and of the drop counters
`define SD_OUT_W 16

// CIC register width, wide enough for 32 cubed plus one guard bit
`define SD_ACC_W 17

// Width of the modulator clock divider field
`define SD_DIV_W 8

// Limits of the decimation ratio, written values are clamped into this range
`define SD_DEC_MIN 4
`define SD_DEC_MAX 32

`endif

//--- logic/sd_demod_pkg.sv
package sd_demod_pkg;

    // Register map of the APB slave
    // Addresses are byte addresses on a 4-bit bus, so each register sits on a word boundary
    typedef enum logic [3:0] {
        CTRL  = 4'h0,
        DIV   = 4'h4,
        DROP0 = 4'h8,
        DROP1 = 4'hC
    } sd_reg_addr_e;

    // Decimator state
    // IDLE holds every filter register cleared while the demodulator is disabled
    typedef enum logic {
        IDLE = 1'b0,
        RUN  = 1'b1
    } sinc_state_e;

    // Configuration shared by the sampler and both decimators
    // The ratio field holds the decimation ratio minus one
    typedef struct packed {
        logic       enable;
        logic [4:0] dec_ratio;
        logic [7:0] div;
    } sd_cfg_t;

    // One filtered sample as it leaves a channel
    // The overrun bit marks a sample that replaced an unread one
    typedef struct packed {
        logic [15:0] value;
        logic        overrun;
    } sd_sample_t;

endpackage

//--- logic/sd_apb_regs.sv
`timescale 1ns/1ps
`include "sd_demod_cfg.svh"

module sd_apb_regs (
    input  logic                  sd_clk,
    input  logic                  reset,
    input  logic                  psel,
    input  logic                  penable,
    input  logic                  pwrite,
    input  logic [3:0]            paddr,
    input  logic [31:0]           pwdata,
    output logic [31:0]           prdata,
    output logic                  pready,
    output logic                  pslverr,
    input  logic [15:0]           drop_count_0,
    input  logic [15:0]           drop_count_1,
    output logic [1:0]            drop_clear,
    output sd_demod_pkg::sd_cfg_t cfg
);

    sd_demod_pkg::sd_reg_addr_e addr;
    logic                       write_en;

    // Turn a written ratio-minus-one field into a legal ratio-minus-one value
    function automatic logic [4:0] clamp_ratio(input logic [4:0] field);
        logic [5:0] ratio;
        logic [5:0] ratio_m1;
        ratio = {1'b0, field} + 6'd1;
        if (ratio < `SD_DEC_MIN) begin
            ratio = `SD_DEC_MIN;
        end else if (ratio > `SD_DEC_MAX) begin
            ratio = `SD_DEC_MAX;
        end
        ratio_m1 = ratio - 6'd1;
        return ratio_m1[4:0];
    endfunction

    assign addr = sd_demod_pkg::sd_reg_addr_e'(paddr);

    // No wait states, so every access completes in its first access phase
    assign write_en = psel && penable && pwrite;
    assign pready   = 1'b1;
    assign pslverr  = 1'b0;

    // Control and divider registers
    // A write lands on the access-phase edge
    always_ff @(posedge sd_clk) begin
        if (reset) begin
            cfg <= '0;
        end else if (write_en) begin
            case (addr)
                sd_demod_pkg::CTRL: begin
                    cfg.enable    <= pwdata[0];
                    cfg.dec_ratio <= clamp_ratio(pwdata[12:8]);
                end
                sd_demod_pkg::DIV: begin
                    cfg.div <= pwdata[`SD_DIV_W-1:0];
                end
                default: begin
                end
            endcase
        end
    end

    // The drop counters live in the output holders
    // A write to their address clears them on the same edge
    always_comb begin
        drop_clear = 2'b00;
        if (write_en) begin
            if (addr == sd_demod_pkg::DROP0) begin
                drop_clear[0] = 1'b1;
            end
            if (addr == sd_demod_pkg::DROP1) begin
                drop_clear[1] = 1'b1;
            end
        end
    end

    // Read mux, unmapped addresses read as zero
    always_comb begin
        prdata = '0;
        case (addr)
            sd_demod_pkg::CTRL: begin
                prdata[0]    = cfg.enable;
                prdata[12:8] = cfg.dec_ratio;
            end
            sd_demod_pkg::DIV:   prdata[`SD_DIV_W-1:0] = cfg.div;
            sd_demod_pkg::DROP0: prdata[15:0] = drop_count_0;
            sd_demod_pkg::DROP1: prdata[15:0] = drop_count_1;
            default: prdata = '0;
        endcase
    end

endmodule

//--- logic/sd_modclk_sampler.sv
`timescale 1ns/1ps
`include "sd_demod_cfg.svh"

module sd_modclk_sampler (
    input  logic                     sd_clk,
    input  logic                     reset,
    input  sd_demod_pkg::sd_cfg_t    cfg,
    input  logic [`SD_CHANNELS-1:0]  data_in,
    output logic                     mod_clk,
    output logic                     sample_strobe,
    output logic [`SD_CHANNELS-1:0]  bits
);

    // Counts sd_clk cycles within one half period of mod_clk
    logic [`SD_DIV_W-1:0] half_cnt;
    logic                 half_done;

    // A half period is div+1 cycles long
    assign half_done = (half_cnt == cfg.div);

    // Divider and modulator clock
    // While disabled the divider is held at zero and mod_clk stays low,
    // so the first rising edge comes div+1 cycles after enable
    always_ff @(posedge sd_clk) begin
        if (reset || !cfg.enable) begin
            half_cnt      <= '0;
            mod_clk       <= 1'b0;
            sample_strobe <= 1'b0;
        end else begin
            sample_strobe <= 1'b0;
            if (half_done) begin
                half_cnt <= '0;
                mod_clk  <= ~mod_clk;
                // The falling transition is the sampling point
                if (mod_clk) begin
                    sample_strobe <= 1'b1;
                end
            end else begin
                half_cnt <= half_cnt + 1'b1;
            end
        end
    end

    // Input capture
    // The modulator changes its output on the rising edge of mod_clk,
    // so half a period later the bit is stable
    always_ff @(posedge sd_clk) begin
        if (cfg.enable && half_done && mod_clk) begin
            bits <= data_in;
        end
    end

endmodule

//--- logic/sinc3_decimator.sv
`timescale 1ns/1ps
`include "sd_demod_cfg.svh"

module sinc3_decimator (
    input  logic                     sd_clk,
    input  logic                     reset,
    input  sd_demod_pkg::sd_cfg_t    cfg,
    input  logic                     sample_strobe,
    input  logic                     bit_in,
    output sd_demod_pkg::sd_sample_t result,
    output logic                     result_valid
);

    sd_demod_pkg::sinc_state_e state;

    // Integrator registers, running at the modulator rate
    logic [`SD_ACC_W-1:0] integ1;
    logic [`SD_ACC_W-1:0] integ2;
    logic [`SD_ACC_W-1:0] integ3;

    // Integrator values including the current input bit
    logic [`SD_ACC_W-1:0] integ1_next;
    logic [`SD_ACC_W-1:0] integ2_next;
    logic [`SD_ACC_W-1:0] integ3_next;

    // Comb delay elements, one decimated sample deep
    logic [`SD_ACC_W-1:0] integ3_dly;
    logic [`SD_ACC_W-1:0] comb1_dly;
    logic [`SD_ACC_W-1:0] comb2_dly;

    // Comb differences for the current decimation point
    logic [`SD_ACC_W-1:0] comb1;
    logic [`SD_ACC_W-1:0] comb2;
    logic [`SD_ACC_W-1:0] comb3;

    logic [4:0]            ratio_cnt;
    logic                  dec_point;
    logic [`SD_OUT_W-1:0]  result_value;

    // Integrator chain
    // The current bit is folded in combinationally, so a decimated sample
    // already includes the bit taken on its own strobe
    always_comb begin
        integ1_next = integ1 + {{(`SD_ACC_W-1){1'b0}}, bit_in};
        integ2_next = integ2 + integ1_next;
        integ3_next = integ3 + integ2_next;
    end

    // Comb chain
    // Arithmetic wraps modulo 2^SD_ACC_W, which is exact because the true
    // output never exceeds R cubed
    always_comb begin
        comb1 = integ3_next - integ3_dly;
        comb2 = comb1 - comb1_dly;
        comb3 = comb2 - comb2_dly;
    end

    // Every R-th strobe since enable is a decimation point
    // The compare uses >= so a ratio lowered on the fly cannot strand the counter
    assign dec_point = (state == sd_demod_pkg::RUN) && sample_strobe &&
                       (ratio_cnt >= cfg.dec_ratio);

    always_ff @(posedge sd_clk) begin
        if (reset || !cfg.enable) begin
            // Disabled, so the filter restarts from empty history
            state        <= sd_demod_pkg::IDLE;
            integ1       <= '0;
            integ2       <= '0;
            integ3       <= '0;
            integ3_dly   <= '0;
            comb1_dly    <= '0;
            comb2_dly    <= '0;
            ratio_cnt    <= '0;
            result_value <= '0;
            result_valid <= 1'b0;
        end else begin
            state        <= sd_demod_pkg::RUN;
            result_valid <= dec_point;
            if ((state == sd_demod_pkg::RUN) && sample_strobe) begin
                integ1 <= integ1_next;
                integ2 <= integ2_next;
                integ3 <= integ3_next;
                if (dec_point) begin
                    ratio_cnt    <= '0;
                    integ3_dly   <= integ3_next;
                    comb1_dly    <= comb1;
                    comb2_dly    <= comb2;
                    result_value <= comb3[`SD_OUT_W-1:0];
                end else begin
                    ratio_cnt <= ratio_cnt + 5'd1;
                end
            end
        end
    end

    // The decimator never reports overruns, that is the holder's job
    assign result = '{value: result_value, overrun: 1'b0};

endmodule

//--- logic/sd_stream_out.sv
`timescale 1ns/1ps
`include "sd_demod_cfg.svh"

module sd_stream_out (
    input  logic                     sd_clk,
    input  logic                     reset,
    input  logic                     enable,
    input  sd_demod_pkg::sd_sample_t result,
    input  logic                     result_valid,
    input  logic                     drop_clear,
    output sd_demod_pkg::sd_sample_t out,
    output logic                     out_valid,
    input  logic                     out_ready,
    output logic [`SD_OUT_W-1:0]     drop_count
);

    logic [`SD_OUT_W-1:0] hold_value;
    logic                 hold_overrun;
    logic                 accept;
    logic                 replace;

    // The consumer takes the held sample
    assign accept  = out_valid && out_ready;

    // A new result lands on a sample nobody has taken yet
    assign replace = result_valid && out_valid && !out_ready;

    assign out = '{value: hold_value, overrun: hold_overrun};

    // Holder control
    // A new result always wins, so only the newest sample stays in flight
    always_ff @(posedge sd_clk) begin
        if (reset || !enable) begin
            out_valid    <= 1'b0;
            hold_overrun <= 1'b0;
        end else begin
            if (result_valid) begin
                out_valid <= 1'b1;
            end else if (accept) begin
                out_valid <= 1'b0;
            end
            // Sticky until a sample has been accepted
            if (replace) begin
                hold_overrun <= 1'b1;
            end else if (accept) begin
                hold_overrun <= 1'b0;
            end
        end
    end

    // Sample payload
    always_ff @(posedge sd_clk) begin
        if (result_valid) begin
            hold_value <= result.value;
        end
    end

    // Drop counter
    // Survives a disable and saturates instead of wrapping
    always_ff @(posedge sd_clk) begin
        if (reset || drop_clear) begin
            drop_count <= '0;
        end else if (replace && (drop_count != {`SD_OUT_W{1'b1}})) begin
            drop_count <= drop_count + 1'b1;
        end
    end

endmodule

//--- logic/sd_demod_top.sv
`timescale 1ns/1ps

module sd_demod_top (
    input  logic                     sd_clk,
    input  logic                     reset,
    input  logic                     psel,
    input  logic                     penable,
    input  logic                     pwrite,
    input  logic [3:0]               paddr,
    input  logic [31:0]              pwdata,
    output logic [31:0]              prdata,
    output logic                     pready,
    output logic                     pslverr,
    input  logic [1:0]               data_in,
    output logic                     mod_clk,
    output sd_demod_pkg::sd_sample_t out_0,
    output logic                     out_0_valid,
    input  logic                     out_0_ready,
    output sd_demod_pkg::sd_sample_t out_1,
    output logic                     out_1_valid,
    input  logic                     out_1_ready
);

    sd_demod_pkg::sd_cfg_t    cfg;
    logic                     sample_strobe;
    logic [1:0]               bits;
    logic [1:0]               drop_clear;
    logic [15:0]              drop_count_0;
    logic [15:0]              drop_count_1;
    sd_demod_pkg::sd_sample_t result_0;
    sd_demod_pkg::sd_sample_t result_1;
    logic                     result_0_valid;
    logic                     result_1_valid;

    // Register block on the APB slave port
    sd_apb_regs i_regs (
        .sd_clk       (sd_clk),
        .reset        (reset),
        .psel         (psel),
        .penable      (penable),
        .pwrite       (pwrite),
        .paddr        (paddr),
        .pwdata       (pwdata),
        .prdata       (prdata),
        .pready       (pready),
        .pslverr      (pslverr),
        .drop_count_0 (drop_count_0),
        .drop_count_1 (drop_count_1),
        .drop_clear   (drop_clear),
        .cfg          (cfg)
    );

    // Modulator clock and the shared sampling point of both channels
    sd_modclk_sampler i_sampler (
        .sd_clk        (sd_clk),
        .reset         (reset),
        .cfg           (cfg),
        .data_in       (data_in),
        .mod_clk       (mod_clk),
        .sample_strobe (sample_strobe),
        .bits          (bits)
    );

    // Channel 0
    sinc3_decimator i_sinc_0 (
        .sd_clk        (sd_clk),
        .reset         (reset),
        .cfg           (cfg),
        .sample_strobe (sample_strobe),
        .bit_in        (bits[0]),
        .result        (result_0),
        .result_valid  (result_0_valid)
    );

    sd_stream_out i_out_0 (
        .sd_clk       (sd_clk),
        .reset        (reset),
        .enable       (cfg.enable),
        .result       (result_0),
        .result_valid (result_0_valid),
        .drop_clear   (drop_clear[0]),
        .out          (out_0),
        .out_valid    (out_0_valid),
        .out_ready    (out_0_ready),
        .drop_count   (drop_count_0)
    );

    // Channel 1
    sinc3_decimator i_sinc_1 (
        .sd_clk        (sd_clk),
        .reset         (reset),
        .cfg           (cfg),
        .sample_strobe (sample_strobe),
        .bit_in        (bits[1]),
        .result        (result_1),
        .result_valid  (result_1_valid)
    );

    sd_stream_out i_out_1 (
        .sd_clk       (sd_clk),
        .reset        (reset),
        .enable       (cfg.enable),
        .result       (result_1),
        .result_valid (result_1_valid),
        .drop_clear   (drop_clear[1]),
        .out          (out_1),
        .out_valid    (out_1_valid),
        .out_ready    (out_1_ready),
        .drop_count   (drop_count_1)
    );

endmodule

//--- dv/sd_demod_tb.sv
`timescale 1ns/1ps

module sd_demod_tb;

    // Outputs checked per channel in every run
    localparam int N_OUT = 8;

    // Sum over all runs of outputs times R times the mod_clk period in sd_clk cycles
    // The last term is the back-pressure run with R=4 and div=3
    localparam int RUN_CYCLES = N_OUT * (8*4 + 4*2 + 4*8 + 16*2 + 16*8 + 32*2 + 32*8 + 4*4)
                              + 6 * 4 * 8;
    // Register accesses, idle checks and reset on top of that
    localparam int MARGIN_CYCLES = 9 * 200 + 100;
    localparam int TIMEOUT_NS = (RUN_CYCLES + MARGIN_CYCLES) * 10;

    logic                     sd_clk;
    logic                     reset;
    logic                     psel;
    logic                     penable;
    logic                     pwrite;
    logic [3:0]               paddr;
    logic [31:0]              pwdata;
    logic [31:0]              prdata;
    logic                     pready;
    logic                     pslverr;
    logic [1:0]               data_in;
    logic                     mod_clk;
    sd_demod_pkg::sd_sample_t out_0;
    logic                     out_0_valid;
    logic                     out_0_ready;
    sd_demod_pkg::sd_sample_t out_1;
    logic                     out_1_valid;
    logic                     out_1_ready;

    int          errors;
    int          cur_r;
    int          density [2] = '{0, 0};
    int          seen [2];
    int          idx [2];
    int          last_value [2];
    bit          expect_ovr [2];

    // Modulator bits per channel in sampling order since the last enable
    bit log_0 [$];
    bit log_1 [$];

    // Samples taken by the consumer, waiting for the comparator
    sd_demod_pkg::sd_sample_t acc_0 [$];
    sd_demod_pkg::sd_sample_t acc_1 [$];

    sd_demod_top i_dut (
        .sd_clk      (sd_clk),
        .reset       (reset),
        .psel        (psel),
        .penable     (penable),
        .pwrite      (pwrite),
        .paddr       (paddr),
        .pwdata      (pwdata),
        .prdata      (prdata),
        .pready      (pready),
        .pslverr     (pslverr),
        .data_in     (data_in),
        .mod_clk     (mod_clk),
        .out_0       (out_0),
        .out_0_valid (out_0_valid),
        .out_0_ready (out_0_ready),
        .out_1       (out_1),
        .out_1_valid (out_1_valid),
        .out_1_ready (out_1_ready)
    );

    initial begin
        sd_clk = 1'b0;
        forever #5 sd_clk = ~sd_clk;
    end

    // One modulator bit with the given density out of 256
    // A density of 256 gives all ones
    function automatic bit draw_bit(input int dens);
        return int'($urandom % 256) < dens;
    endfunction

    function automatic bit logged_bit(input int ch, input int pos);
        if (ch == 0) begin
            return (pos < log_0.size()) ? log_0[pos] : 1'b0;
        end
        return (pos < log_1.size()) ? log_1[pos] : 1'b0;
    endfunction

    // Reference sinc3 output number k
    // A third-order CIC is three cascaded boxes of length R, so the weight of a bit
    // j positions back is the number of ways to split j into three parts below R
    function automatic int expected_output(input int ch, input int k, input int r);
        int n;
        int sum;
        int w;
        int c;
        n = k * r;
        sum = 0;
        for (int j = 0; j <= 3 * r - 3; j++) begin
            // Bits are numbered from one and anything before the first is empty history
            if ((n - j >= 1) && logged_bit(ch, n - j - 1)) begin
                w = 0;
                for (int a = 0; a < r; a++) begin
                    for (int b = 0; b < r; b++) begin
                        c = j - a - b;
                        if (c >= 0 && c < r) begin
                            w++;
                        end
                    end
                end
                sum += w;
            end
        end
        return sum;
    endfunction

    // Ratio as the register block should store it
    function automatic int legal_ratio(input int ratio);
        if (ratio < 4) begin
            return 4;
        end
        if (ratio > 32) begin
            return 32;
        end
        return ratio;
    endfunction

    function automatic logic [31:0] ctrl_word(input int ratio, input bit en);
        logic [31:0] w;
        w = '0;
        w[12:8] = 5'(ratio - 1);
        w[0] = en;
        return w;
    endfunction

    // The modulator model presents a new bit on every rising edge of mod_clk
    initial begin
        bit b0;
        bit b1;
        data_in = 2'b00;
        void'($urandom(32'h1136_fe98));
        forever begin
            @(posedge mod_clk);
            #1;
            b0 = draw_bit(density[0]);
            b1 = draw_bit(density[1]);
            data_in = {b1, b0};
            log_0.push_back(b0);
            log_1.push_back(b1);
        end
    end

    // Handshakes are sampled mid-cycle where valid, ready and data are settled
    always @(negedge sd_clk) begin
        if (!reset) begin
            if (out_0_valid && out_0_ready) begin
                acc_0.push_back(out_0);
            end
            if (out_1_valid && out_1_ready) begin
                acc_1.push_back(out_1);
            end
        end
    end

    task automatic check_output(input int ch, input sd_demod_pkg::sd_sample_t s);
        int exp_value;
        idx[ch] = idx[ch] + 1;
        seen[ch] = seen[ch] + 1;
        exp_value = expected_output(ch, idx[ch], cur_r);
        if (int'(s.value) != exp_value) begin
            errors++;
            $display("ERROR out_%0d.value (output %0d): got %h expected %h",
                     ch, idx[ch], s.value, exp_value[15:0]);
        end
        if (s.overrun != expect_ovr[ch]) begin
            errors++;
            $display("ERROR out_%0d.overrun (output %0d): got %h expected %h",
                     ch, idx[ch], s.overrun, expect_ovr[ch]);
        end
        // Overrun is flagged on the first sample taken after the drops only
        expect_ovr[ch] = 1'b0;
        last_value[ch] = int'(s.value);
    endtask

    // Comparator
    always @(posedge sd_clk) begin
        while (acc_0.size() > 0) begin
            check_output(0, acc_0.pop_front());
        end
        while (acc_1.size() > 0) begin
            check_output(1, acc_1.pop_front());
        end
    end

    task automatic check_response();
        if (pready !== 1'b1 || pslverr !== 1'b0) begin
            errors++;
            $display("ERROR pready/pslverr: got %h/%h expected 1/0", pready, pslverr);
        end
    endtask

    task automatic apb_write(input logic [3:0] addr, input logic [31:0] data);
        @(posedge sd_clk);
        #1;
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = 1'b1;
        paddr   = addr;
        pwdata  = data;
        @(posedge sd_clk);
        #1;
        penable = 1'b1;
        @(negedge sd_clk);
        check_response();
        @(posedge sd_clk);
        #1;
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
    endtask

    task automatic apb_read(input logic [3:0] addr, output logic [31:0] data);
        @(posedge sd_clk);
        #1;
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = 1'b0;
        paddr   = addr;
        @(posedge sd_clk);
        #1;
        penable = 1'b1;
        // prdata is combinational so the middle of the access phase shows what the edge returns
        @(negedge sd_clk);
        data = prdata;
        check_response();
        @(posedge sd_clk);
        #1;
        psel    = 1'b0;
        penable = 1'b0;
    endtask

    task automatic expect_reg(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            errors++;
            $display("ERROR %s: got %h expected %h", name, got, exp);
        end
    endtask

    // Fresh history for a run
    // It is called while the demodulator is disabled
    task automatic start_run(input int r, input int dens0, input int dens1);
        log_0.delete();
        log_1.delete();
        cur_r = r;
        density[0] = dens0;
        density[1] = dens1;
        for (int ch = 0; ch < 2; ch++) begin
            seen[ch] = 0;
            idx[ch] = 0;
            last_value[ch] = 0;
            expect_ovr[ch] = 1'b0;
        end
    endtask

    task automatic wait_outputs(input int n0, input int n1);
        while (seen[0] < n0 || seen[1] < n1) begin
            @(negedge sd_clk);
        end
    endtask

    task automatic measure_period(input int div);
        time t0;
        time t1;
        int expected;
        @(posedge mod_clk);
        t0 = $time;
        @(posedge mod_clk);
        t1 = $time;
        expected = 2 * (div + 1) * 10;
        if (int'(t1 - t0) != expected) begin
            errors++;
            $display("ERROR mod_clk period in ns: got %h expected %h", int'(t1 - t0), expected);
        end
    endtask

    // Both valids and mod_clk must stay low once the disable has landed
    task automatic check_idle(input int cycles);
        @(posedge sd_clk);
        #1;
        for (int i = 0; i < cycles; i++) begin
            @(negedge sd_clk);
            if (out_0_valid || out_1_valid || mod_clk) begin
                errors++;
                $display("A valid or mod_clk went high while the demodulator was disabled");
            end
        end
    endtask

    task automatic run_case(input int ratio, input int div, input int dens0, input int dens1);
        logic [31:0] rd;
        int r_exp;
        r_exp = legal_ratio(ratio);
        start_run(r_exp, dens0, dens1);
        apb_write(sd_demod_pkg::DIV, 32'(div));
        apb_write(sd_demod_pkg::CTRL, ctrl_word(ratio, 1'b1));
        apb_read(sd_demod_pkg::CTRL, rd);
        expect_reg("CTRL", rd, ctrl_word(r_exp, 1'b1));
        measure_period(div);
        wait_outputs(N_OUT, N_OUT);
        apb_write(sd_demod_pkg::CTRL, 32'h0);
    endtask

    // Channel 1 stalls across two decimation points while channel 0 keeps running
    task automatic check_backpressure();
        logic [31:0] rd;
        start_run(4, 96, 176);
        @(posedge sd_clk);
        #1;
        out_1_ready = 1'b0;
        apb_write(sd_demod_pkg::DIV, 32'd3);
        apb_write(sd_demod_pkg::CTRL, ctrl_word(4, 1'b1));
        wait_outputs(3, 0);
        if (out_1_valid !== 1'b1) begin
            errors++;
            $display("Channel 1 holds no sample while its consumer is stalled");
        end
        apb_read(sd_demod_pkg::DROP1, rd);
        expect_reg("DROP1", rd, 32'd2);
        apb_write(sd_demod_pkg::DROP1, 32'h0);
        apb_read(sd_demod_pkg::DROP1, rd);
        expect_reg("DROP1 after clear", rd, 32'd0);
        // Outputs 1 and 2 were replaced, so the held one is output 3
        idx[1] = idx[1] + 2;
        expect_ovr[1] = 1'b1;
        @(posedge sd_clk);
        #1;
        out_1_ready = 1'b1;
        wait_outputs(6, 4);
        apb_read(sd_demod_pkg::DROP0, rd);
        expect_reg("DROP0", rd, 32'd0);
        apb_write(sd_demod_pkg::CTRL, 32'h0);
    endtask

    initial begin
        int ratios [3] = '{4, 16, 32};
        errors      = 0;
        cur_r       = 4;
        reset       = 1'b1;
        psel        = 1'b0;
        penable     = 1'b0;
        pwrite      = 1'b0;
        paddr       = 4'h0;
        pwdata      = 32'h0;
        out_0_ready = 1'b1;
        out_1_ready = 1'b1;
        repeat (16) @(posedge sd_clk);
        #1;
        reset = 1'b0;
        check_idle(20);

        // Constant ones on channel 0 settle at R cubed, constant zeros on channel 1 at zero
        run_case(8, 1, 256, 0);
        expect_reg("out_0.value settled", 32'(last_value[0]), 32'd512);
        expect_reg("out_1.value settled", 32'(last_value[1]), 32'd0);
        check_idle(20);

        for (int i = 0; i < 3; i++) begin
            run_case(ratios[i], 0, 80, 170);
            run_case(ratios[i], 3, 200, 40);
        end

        check_backpressure();

        // A ratio of 2 is raised to the minimum of 4
        run_case(2, 1, 120, 200);
        check_idle(40);

        $display("Checks finished with %0d errors", errors);
        if (errors == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

    // Watchdog
    initial begin
        #(TIMEOUT_NS);
        $display("Timeout after %0d ns, the outputs stopped arriving", TIMEOUT_NS);
        $display("Checks finished with %0d errors", errors);
        $display("STATUS: FAIL");
        $finish;
    end

endmodule

//--- sd_demod_top.f
+incdir+logic
logic/sd_demod_pkg.sv
logic/sd_apb_regs.sv
logic/sd_modclk_sampler.sv
logic/sinc3_decimator.sv
logic/sd_stream_out.sv
logic/sd_demod_top.sv
dv/sd_demod_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Builds the testbench with Verilator, runs it and checks the log for a pass
set -e

cd "$(dirname "$0")"
mkdir -p build

verilator --binary --timing \
    --top-module sd_demod_tb \
    -Mdir build/obj \
    -o sd_demod_sim \
    -f sd_demod_top.f

./build/obj/sd_demod_sim > build/sim.log 2>&1
cat build/sim.log

if grep -q "^STATUS: PASS$" build/sim.log; then
    exit 0
else
    echo "Simulation did not pass, see build/sim.log"
    exit 1
fi
